/* tests/i2c_init_tests.dat */
# W <expected 24-bit command word in hex>, in table order
# S <frame> <ack slot> withholds that ack, S none gives every ack
W 341E00
W 340815
W 340A00
W 340C00
W 340E42
W 341019
W 341201
S none
S 2 1
S none
S 0 0
S 6 2
S 3 0
S none

/* sources.f */
+incdir+include
verilog/i2c_init_pkg.sv
verilog/i2c_cmd_if.sv
verilog/init_cmd_sequencer.sv
verilog/i2c_frame_tx.sv
verilog/i2c_line_driver.sv
verilog/i2c_codec_init.sv
tests/tb_i2c_codec_init.sv

/* Makefile */
SIM := obj_dir/Vtb_i2c_codec_init

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard include/*.svh verilog/*.sv tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_i2c_codec_init -f sources.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

/* tests/tb_i2c_codec_init.sv */
`timescale 1ns/1ps
`include "i2c_init_params.svh"

module tb_i2c_codec_init;

    logic i_clk, i_rst_n, i_start, i_sdat_in;
    logic o_sclk, o_sdat, o_oen, o_finished, o_ack_error;

    i2c_init_pkg::cmd_word_t exp_words [$];   // Table words from the data file
    i2c_init_pkg::cmd_word_t rx_words [$];    // Words decoded by the slave
    i2c_init_pkg::cmd_word_t shift_word;
    int   scen_frame [$];                     // -1 when every ack is given
    int   scen_slot [$];
    int   frame_cnt = 0;                      // Starts seen since time zero
    int   bit_cnt, ack_cnt;
    int   target_frame = -1;
    int   target_slot = -1;
    bit   in_frame = 1'b0;
    bit   tests_loaded = 1'b0;
    logic prev_scl = 1'b1;
    logic prev_sda = 1'b1;

    i2c_codec_init dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string name, input i2c_init_pkg::cmd_word_t got,
                              input i2c_init_pkg::cmd_word_t exp);
        if (got !== exp)
            report_failure($sformatf("ERROR at %0d ns: %s = %h, expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input i2c_init_pkg::cmd_idx_t got,
                               input i2c_init_pkg::cmd_idx_t exp);
        if (got !== exp)
            report_failure($sformatf("ERROR at %0d ns: %s = %0d, expected %0d",
                                     $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("ERROR at %0d ns: %s = %b, expected %b",
                                     $time, name, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic load_tests();
        int    fd;
        int    f;
        int    s;
        string line;
        i2c_init_pkg::cmd_word_t w;
        fd = $fopen("tests/i2c_init_tests.dat", "r");
        if (fd == 0)
            report_failure("Cannot open tests/i2c_init_tests.dat for reading");
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "W %h", w) == 1) begin
                exp_words.push_back(w);
            end else if ($sscanf(line, "S %d %d", f, s) == 2) begin
                scen_frame.push_back(f);
                scen_slot.push_back(s);
            end else if (line.len() >= 6 && line.substr(0, 5) == "S none") begin
                scen_frame.push_back(-1);
                scen_slot.push_back(-1);
            end
        end
        $fclose(fd);
        if (exp_words.size() != `I2C_INIT_NUM_CMDS || scen_frame.size() == 0)
            report_failure("Data file does not hold seven words and at least one scenario");
    endtask

    // Bus decode mid-cycle, where the registered pins have settled
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            if (prev_scl && o_sclk && prev_sda && !o_sdat) begin   // Start
                if (in_frame)
                    report_failure("Start condition inside a frame");
                in_frame   = 1'b1;
                frame_cnt  = frame_cnt + 1;
                bit_cnt    = 0;
                ack_cnt    = 0;
                shift_word = '0;
            end else if (prev_scl && o_sclk && !prev_sda && o_sdat) begin   // Stop
                if (!in_frame || bit_cnt != 24 || ack_cnt != 3)
                    report_failure($sformatf("Stop after %0d data bits and %0d ack slots",
                                             bit_cnt, ack_cnt));
                rx_words.push_back(shift_word);
                in_frame = 1'b0;
            end else if (!prev_scl && o_sclk) begin
                if (!in_frame)
                    report_failure("SCL pulse outside a frame");
                if (prev_sda !== o_sdat)
                    report_failure("SDA changed together with a rising SCL");
                // Rise after the last slot belongs to the stop condition
                if (bit_cnt + ack_cnt < `I2C_FRAME_SLOTS) begin
                    if (bit_cnt == 8 * (ack_cnt + 1)) begin
                        if (o_oen !== 1'b0)
                            report_failure("SDA still driven in an ack slot");
                        ack_cnt = ack_cnt + 1;
                    end else begin
                        if (o_oen !== 1'b1)
                            report_failure("SDA released in a data slot");
                        shift_word = {shift_word[22:0], o_sdat};
                        bit_cnt    = bit_cnt + 1;
                    end
                end
            end
            if (!o_oen && !in_frame)
                report_failure("SDA released outside a frame");
        end
        prev_scl = o_sclk;
        prev_sda = o_sdat;
    end

    // Codec side of SDA, low in released slots unless this ack is withheld
    initial begin
        i_sdat_in = 1'b1;
        forever begin
            next_cycle();
            if (o_oen)
                i_sdat_in = o_sdat;
            else
                i_sdat_in = (frame_cnt - 1 == target_frame && ack_cnt == target_slot);
        end
    end

    initial begin
        int limit;
        wait (tests_loaded);
        limit = scen_frame.size() * (`I2C_INIT_NUM_CMDS * 60 + 20 + 100) + 200;
        repeat (limit) @(posedge i_clk);
        report_failure($sformatf("Watchdog expired after %0d cycles", limit));
    end

    task automatic run_scenario(input int n);
        int base;
        int exp_frames;
        base         = frame_cnt;
        exp_frames   = (scen_frame[n] < 0) ? `I2C_INIT_NUM_CMDS : scen_frame[n] + 1;
        target_frame = (scen_frame[n] < 0) ? -1 : base + scen_frame[n];
        target_slot  = scen_slot[n];
        repeat ($urandom % 16) next_cycle();
        i_start = 1'b0;   // Falling edge starts the sequence
        next_cycle();
        i_start = 1'b1;
        check_flag("o_finished", o_finished, 1'b0);
        check_flag("o_ack_error", o_ack_error, 1'b0);
        while (o_finished !== 1'b1 && o_ack_error !== 1'b1)
            next_cycle();
        repeat (64) next_cycle();   // Long enough for one more frame to show up
        check_flag("o_finished", o_finished, scen_frame[n] < 0);
        check_flag("o_ack_error", o_ack_error, scen_frame[n] >= 0);
        if (frame_cnt - base > `I2C_INIT_NUM_CMDS)
            report_failure("More frames than table entries");
        check_count("frame count", i2c_init_pkg::cmd_idx_t'(frame_cnt - base),
                    i2c_init_pkg::cmd_idx_t'(exp_frames));
        for (int i = 0; i < exp_frames; i++)
            check_word($sformatf("frame %0d word", i), rx_words[base + i], exp_words[i]);
    endtask

    initial begin
        i_rst_n = 1'b1;
        i_start = 1'b0;
        void'($urandom(99643));
        load_tests();
        tests_loaded = 1'b1;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst_n = 1'b0;
        // Idle state must hold through a rising start
        for (int i = 0; i < 12; i++) begin
            if (i == 4)
                i_start = 1'b1;
            check_flag("o_sclk", o_sclk, 1'b1);
            check_flag("o_sdat", o_sdat, 1'b1);
            check_flag("o_oen", o_oen, 1'b1);
            check_flag("o_finished", o_finished, 1'b0);
            check_flag("o_ack_error", o_ack_error, 1'b0);
            next_cycle();
        end
        check_count("frame count", i2c_init_pkg::cmd_idx_t'(frame_cnt), 3'd0);
        for (int n = 0; n < scen_frame.size(); n++)
            run_scenario(n);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* verilog/i2c_codec_init.sv */
`timescale 1ns/1ps

module i2c_codec_init (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_sdat_in,
    output logic o_sclk,
    output logic o_sdat,
    output logic o_oen,
    output logic o_finished,
    output logic o_ack_error
);

    i2c_cmd_if cmd_if ();

    logic scl_nxt;
    logic sda_nxt;
    logic oen_nxt;
    logic ack_sample;
    logic ack_bad;

    init_cmd_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .o_finished  (o_finished),
        .o_ack_error (o_ack_error),
        .cmd         (cmd_if.seq)
    );

    i2c_frame_tx u_tx (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .cmd          (cmd_if.tx),
        .o_scl_nxt    (scl_nxt),
        .o_sda_nxt    (sda_nxt),
        .o_oen_nxt    (oen_nxt),
        .o_ack_sample (ack_sample),
        .i_ack_bad    (ack_bad)
    );

    i2c_line_driver u_drv (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_scl_nxt    (scl_nxt),
        .i_sda_nxt    (sda_nxt),
        .i_oen_nxt    (oen_nxt),
        .i_ack_sample (ack_sample),
        .i_sda_in     (i_sdat_in),
        .o_sclk       (o_sclk),
        .o_sdat       (o_sdat),
        .o_oen        (o_oen),
        .o_ack_bad    (ack_bad)
    );

endmodule

/* verilog/i2c_line_driver.sv */
`timescale 1ns/1ps

module i2c_line_driver (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_scl_nxt,
    input  logic i_sda_nxt,
    input  logic i_oen_nxt,
    input  logic i_ack_sample,
    input  logic i_sda_in,
    output logic o_sclk,
    output logic o_sdat,
    output logic o_oen,
    output logic o_ack_bad
);

    logic sda_s1;
    logic sda_s2;
    logic ack_q;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            o_sclk <= 1'b1;   // Bus idles high
            o_sdat <= 1'b1;
            o_oen  <= 1'b1;
            sda_s1 <= 1'b1;
            sda_s2 <= 1'b1;
            ack_q  <= 1'b0;
        end else begin
            o_sclk <= i_scl_nxt;
            o_sdat <= i_sda_nxt;
            o_oen  <= i_oen_nxt;
            sda_s1 <= i_sda_in;   // Two-flop synchronizer
            sda_s2 <= sda_s1;
            ack_q  <= i_ack_sample;
        end
    end

    // Synchronized SDA still high in the released slot means no ack
    assign o_ack_bad = ack_q & sda_s2;

    // Released slot spans one SCL low and one SCL high phase, then SDA is driven again
    a_oen_slot: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $fell(o_oen) |-> !o_sclk ##1 (o_sclk && !o_oen) ##1 (o_oen && !o_sclk))
        else $error("SDA released outside an ack slot");

endmodule

/* verilog/i2c_frame_tx.sv */
`timescale 1ns/1ps
`include "i2c_init_params.svh"

module i2c_frame_tx (
    input  logic  i_clk,
    input  logic  i_rst_n,
    i2c_cmd_if.tx cmd,
    output logic  o_scl_nxt,
    output logic  o_sda_nxt,
    output logic  o_oen_nxt,
    output logic  o_ack_sample,
    input  logic  i_ack_bad
);

    localparam i2c_init_pkg::slot_cnt_t LAST_SLOT =
        i2c_init_pkg::slot_cnt_t'(`I2C_FRAME_SLOTS - 1);
    localparam logic [3:0] ACK_BIT = 4'(`I2C_BITS_PER_BYTE);

    i2c_init_pkg::tx_state_e  state_q;
    i2c_init_pkg::slot_cnt_t  slot_q;
    logic [3:0]               bit_q;      // Position in byte, ACK_BIT marks the ack slot
    i2c_init_pkg::cmd_word_t  shift_q;
    logic                     nack_q;
    logic                     ack_sample_q;
    logic                     ack_slot;

    assign ack_slot = (bit_q == ACK_BIT);

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_q      <= i2c_init_pkg::TX_IDLE;
            slot_q       <= '0;
            bit_q        <= '0;
            nack_q       <= 1'b0;
            ack_sample_q <= 1'b0;
        end else begin
            // Lines up with the pin-level SCL high of the ack slot
            ack_sample_q <= (state_q == i2c_init_pkg::TX_HIGH) && ack_slot;
            if (i_ack_bad) begin
                nack_q <= 1'b1;
            end
            case (state_q)
                i2c_init_pkg::TX_IDLE: begin
                    if (cmd.cmd_go) begin
                        state_q <= i2c_init_pkg::TX_START;
                        slot_q  <= '0;
                        bit_q   <= '0;
                        nack_q  <= 1'b0;
                    end
                end
                i2c_init_pkg::TX_START: state_q <= i2c_init_pkg::TX_LOW;
                i2c_init_pkg::TX_LOW:   state_q <= i2c_init_pkg::TX_HIGH;
                i2c_init_pkg::TX_HIGH: begin
                    slot_q <= slot_q + 1'b1;
                    if (ack_slot) begin
                        bit_q <= '0;
                    end else begin
                        bit_q <= bit_q + 1'b1;
                    end
                    if (slot_q == LAST_SLOT) begin
                        state_q <= i2c_init_pkg::TX_STOP_LOW;
                    end else begin
                        state_q <= i2c_init_pkg::TX_LOW;
                    end
                end
                i2c_init_pkg::TX_STOP_LOW:  state_q <= i2c_init_pkg::TX_STOP_HIGH;
                i2c_init_pkg::TX_STOP_HIGH: state_q <= i2c_init_pkg::TX_STOP_REL;
                i2c_init_pkg::TX_STOP_REL:  state_q <= i2c_init_pkg::TX_IDLE;
                default:                    state_q <= i2c_init_pkg::TX_IDLE;
            endcase
        end
    end

    // Data shifts on the way from SCL high back to low, MSB first
    always_ff @(posedge i_clk) begin
        if (state_q == i2c_init_pkg::TX_IDLE && cmd.cmd_go) begin
            shift_q <= cmd.cmd_word;
        end else if (state_q == i2c_init_pkg::TX_HIGH && !ack_slot) begin
            shift_q <= {shift_q[22:0], 1'b0};
        end
    end

    always_comb begin
        o_scl_nxt = 1'b1;   // Idle bus
        o_sda_nxt = 1'b1;
        o_oen_nxt = 1'b1;
        case (state_q)
            i2c_init_pkg::TX_START: o_sda_nxt = 1'b0;
            i2c_init_pkg::TX_LOW,
            i2c_init_pkg::TX_HIGH: begin
                o_scl_nxt = (state_q == i2c_init_pkg::TX_HIGH);
                o_sda_nxt = ack_slot ? 1'b1 : shift_q[23];
                o_oen_nxt = ~ack_slot;   // Released for the codec's ack
            end
            i2c_init_pkg::TX_STOP_LOW: begin
                o_scl_nxt = 1'b0;
                o_sda_nxt = 1'b0;
            end
            i2c_init_pkg::TX_STOP_HIGH: o_sda_nxt = 1'b0;
            default: ;
        endcase
    end

    assign cmd.cmd_done = (state_q == i2c_init_pkg::TX_STOP_REL);
    assign cmd.cmd_nack = nack_q;
    assign o_ack_sample = ack_sample_q;

    // Only start and stop may move SDA while SCL stays high
    a_sda_stable: assert property (@(posedge i_clk) disable iff (i_rst_n)
        ($past(o_scl_nxt) && o_scl_nxt &&
         !(state_q inside {i2c_init_pkg::TX_START, i2c_init_pkg::TX_STOP_REL}))
        |-> $stable(o_sda_nxt))
        else $error("SDA changed while SCL high");

endmodule

/* verilog/init_cmd_sequencer.sv */
`timescale 1ns/1ps
`include "i2c_init_params.svh"

module init_cmd_sequencer (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_start,
    output logic   o_finished,
    output logic   o_ack_error,
    i2c_cmd_if.seq cmd
);

    // Codec power-up writes in the order they go out on the bus
    localparam i2c_init_pkg::cmd_word_t INIT_TABLE [`I2C_INIT_NUM_CMDS] = '{
        {`I2C_DEV_ADDR_W, 7'h0f, 9'h000},   // Reset
        {`I2C_DEV_ADDR_W, 7'h04, 9'h015},   // Analogue path
        {`I2C_DEV_ADDR_W, 7'h05, 9'h000},   // Digital path
        {`I2C_DEV_ADDR_W, 7'h06, 9'h000},   // Power down
        {`I2C_DEV_ADDR_W, 7'h07, 9'h042},   // Interface format
        {`I2C_DEV_ADDR_W, 7'h08, 9'h019},   // Sampling
        {`I2C_DEV_ADDR_W, 7'h09, 9'h001}    // Active
    };

    localparam i2c_init_pkg::cmd_idx_t LAST_IDX =
        i2c_init_pkg::cmd_idx_t'(`I2C_INIT_NUM_CMDS - 1);

    i2c_init_pkg::seq_state_e state_q;
    i2c_init_pkg::seq_state_e state_d;
    i2c_init_pkg::cmd_idx_t   idx_q;
    i2c_init_pkg::cmd_idx_t   idx_d;
    logic                     start_q;
    logic                     start_fall;

    assign start_fall = start_q & ~i_start;

    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        case (state_q)
            // A falling edge only counts when no sequence is running
            i2c_init_pkg::SEQ_IDLE,
            i2c_init_pkg::SEQ_DONE,
            i2c_init_pkg::SEQ_ABORT: begin
                if (start_fall) begin
                    idx_d   = '0;
                    state_d = i2c_init_pkg::SEQ_ISSUE;
                end
            end
            i2c_init_pkg::SEQ_ISSUE: state_d = i2c_init_pkg::SEQ_WAIT;
            i2c_init_pkg::SEQ_WAIT: begin
                if (cmd.cmd_done) begin
                    if (cmd.cmd_nack) begin
                        state_d = i2c_init_pkg::SEQ_ABORT;   // Codec did not answer
                    end else if (idx_q == LAST_IDX) begin
                        state_d = i2c_init_pkg::SEQ_DONE;
                    end else begin
                        idx_d   = idx_q + 1'b1;
                        state_d = i2c_init_pkg::SEQ_ISSUE;
                    end
                end
            end
            default: state_d = i2c_init_pkg::SEQ_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_q <= i2c_init_pkg::SEQ_IDLE;
            idx_q   <= '0;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
            start_q <= i_start;
        end
    end

    assign cmd.cmd_go   = (state_q == i2c_init_pkg::SEQ_ISSUE);
    assign cmd.cmd_word = INIT_TABLE[idx_q];

    // Flags are sticky until the next start edge
    assign o_finished  = (state_q == i2c_init_pkg::SEQ_DONE);
    assign o_ack_error = (state_q == i2c_init_pkg::SEQ_ABORT);

    // The transmitter only ends a frame that was requested and is still awaited
    a_done_in_wait: assert property (@(posedge i_clk) disable iff (i_rst_n)
        cmd.cmd_done |-> (state_q == i2c_init_pkg::SEQ_WAIT))
        else $error("cmd_done without a pending request");

endmodule

/* verilog/i2c_cmd_if.sv */
`timescale 1ns/1ps

// One register write handed from the sequencer to the frame transmitter
interface i2c_cmd_if;

    logic                    cmd_go;     // Single-cycle request
    i2c_init_pkg::cmd_word_t cmd_word;   // Held while the frame runs
    logic                    cmd_done;   // End of stop condition
    logic                    cmd_nack;   // Valid with cmd_done

    modport seq (
        output cmd_go,
        output cmd_word,
        input  cmd_done,
        input  cmd_nack
    );

    modport tx (
        input  cmd_go,
        input  cmd_word,
        output cmd_done,
        output cmd_nack
    );

endinterface

/* verilog/i2c_init_pkg.sv */
package i2c_init_pkg;

    // Device byte, 7-bit register address, 9-bit register data
    typedef logic [23:0] cmd_word_t;
    typedef logic [2:0]  cmd_idx_t;    // Table index
    typedef logic [4:0]  slot_cnt_t;   // Bit slot inside one frame

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT,
        SEQ_DONE,
        SEQ_ABORT
    } seq_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_LOW,
        TX_HIGH,
        TX_STOP_LOW,
        TX_STOP_HIGH,
        TX_STOP_REL
    } tx_state_e;

endpackage

/* include/i2c_init_params.svh */
`ifndef I2C_INIT_PARAMS_SVH
`define I2C_INIT_PARAMS_SVH

// Entries in the power-up register table
`define I2C_INIT_NUM_CMDS  7

// Codec device address, write bit in bit 0
`define I2C_DEV_ADDR_W     8'h34

// Frame geometry
`define I2C_BITS_PER_BYTE  8
`define I2C_FRAME_SLOTS    27   // 24 data slots plus 3 ack slots

`endif
